//--- common/complete_if.sv
interface complete_if import rob_pkg::*; #(
    parameter int tag_w = 3
);
    logic              valid;
    logic [tag_w-1:0]  tag;
    logic [data_w-1:0] value;
    logic [data_w-1:0] addr;
    logic [3:0]        strobe;
    logic              taken;

    // execution unit side
    modport src (
        output valid, tag, value, addr, strobe, taken
    );

    // reorder buffer side, always accepts
    modport dst (
        input valid, tag, value, addr, strobe, taken
    );

endinterface

//--- common/dispatch_if.sv
interface dispatch_if import rob_pkg::*; #(
    parameter int tag_w = 3
);
    logic              valid;
    logic [tag_w-1:0]  tag;
    op_e               op;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] pc;
    logic [data_w-1:0] offset;

    // reorder buffer side
    modport src (
        output valid, tag, op, a, b, pc, offset
    );

    // execution unit side, never stalls
    modport dst (
        input valid, tag, op, a, b, pc, offset
    );

endinterface

//--- common/rob_pkg.sv
package rob_pkg;

    // datapath and architectural register widths
    localparam int data_w = 32;
    localparam int reg_w  = 5;

    // opcodes seen on the issue port
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_beq,
        op_bne,
        op_sb,
        op_sh,
        op_sw
    } op_e;

    // what an entry does when it reaches the head
    typedef enum logic [1:0] {
        kind_reg,
        kind_store,
        kind_branch
    } kind_e;

endpackage

//--- logic/alu_unit.sv
module alu_unit import rob_pkg::*; #(
    parameter int tag_w = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    dispatch_if.dst dispatch,
    complete_if.src complete
);
    logic [data_w-1:0] result;
    logic [data_w-1:0] redirect;
    logic              taken;

    logic              valid_q;
    logic [tag_w-1:0]  tag_q;
    logic [data_w-1:0] value_q;
    logic [data_w-1:0] addr_q;
    logic              taken_q;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (dispatch.op)
            op_add: result = dispatch.a + dispatch.b;
            op_sub: result = dispatch.a - dispatch.b;
            op_xor: result = dispatch.a ^ dispatch.b;
            op_beq: taken  = (dispatch.a == dispatch.b);
            op_bne: taken  = (dispatch.a != dispatch.b);
            default: result = '0;
        endcase
    end

    // fall-through is the next sequential word
    assign redirect = taken ? dispatch.pc + dispatch.offset : dispatch.pc + data_w'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dispatch.valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch.valid) begin
            tag_q   <= dispatch.tag;
            value_q <= result;
            addr_q  <= redirect;
            taken_q <= taken;
        end
    end

    assign complete.valid  = valid_q;
    assign complete.tag    = tag_q;
    assign complete.value  = value_q;
    assign complete.addr   = addr_q;
    assign complete.strobe = 4'b0000;
    assign complete.taken  = taken_q;

endmodule

//--- logic/ooo_backend_top.sv
module ooo_backend_top import rob_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    output logic              issue_ready,
    input  op_e               issue_op,
    input  logic [reg_w-1:0]  issue_rd,
    input  logic [data_w-1:0] issue_a,
    input  logic [data_w-1:0] issue_b,
    input  logic [data_w-1:0] issue_pc,
    input  logic [data_w-1:0] issue_offset,
    input  logic              issue_pred_taken,
    output logic              commit_valid,
    output logic [reg_w-1:0]  commit_rd,
    output logic [data_w-1:0] commit_value,
    output logic              store_valid,
    output logic [data_w-1:0] store_addr,
    output logic [3:0]        store_strobe,
    output logic [data_w-1:0] store_data,
    output logic              flush,
    output logic [data_w-1:0] flush_pc
);
    localparam int tag_w = $clog2(rob_depth);

    dispatch_if #(.tag_w(tag_w)) alu_dispatch ();
    dispatch_if #(.tag_w(tag_w)) store_dispatch ();
    complete_if #(.tag_w(tag_w)) alu_complete ();
    complete_if #(.tag_w(tag_w)) store_complete ();

    reorder_buffer #(
        .rob_depth (rob_depth),
        .tag_w     (tag_w)
    ) reorder_buffer_i (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .issue_ready      (issue_ready),
        .issue_op         (issue_op),
        .issue_rd         (issue_rd),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .issue_pc         (issue_pc),
        .issue_offset     (issue_offset),
        .issue_pred_taken (issue_pred_taken),
        .alu_dispatch     (alu_dispatch.src),
        .store_dispatch   (store_dispatch.src),
        .alu_complete     (alu_complete.dst),
        .store_complete   (store_complete.dst),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_value     (commit_value),
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_strobe     (store_strobe),
        .store_data       (store_data),
        .flush            (flush),
        .flush_pc         (flush_pc)
    );

    alu_unit #(
        .tag_w (tag_w)
    ) alu_unit_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .dispatch (alu_dispatch.dst),
        .complete (alu_complete.src)
    );

    store_align_unit #(
        .tag_w (tag_w)
    ) store_align_unit_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .dispatch (store_dispatch.dst),
        .complete (store_complete.src)
    );

endmodule

//--- logic/store_align_unit.sv
module store_align_unit import rob_pkg::*; #(
    parameter int tag_w = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    dispatch_if.dst dispatch,
    complete_if.src complete
);
    logic              s1_valid;
    logic              s2_valid;
    logic              s3_valid;
    logic [tag_w-1:0]  s1_tag;
    logic [tag_w-1:0]  s2_tag;
    logic [tag_w-1:0]  s3_tag;
    op_e               s1_op;
    logic [data_w-1:0] s1_addr;
    logic [data_w-1:0] s1_data;
    logic [data_w-1:0] s2_addr;
    logic [data_w-1:0] s2_data;
    logic [data_w-1:0] s3_addr;
    logic [data_w-1:0] s3_data;
    logic [3:0]        s2_strobe;
    logic [3:0]        s3_strobe;
    logic [3:0]        lane_strobe;
    logic [data_w-1:0] lane_data;

    // size from opcode, lane from low address bits
    always_comb begin
        case (s1_op)
            op_sb: begin
                lane_strobe = 4'b0001 << s1_addr[1:0];
                lane_data   = data_w'(s1_data[7:0]) << {s1_addr[1:0], 3'b000};
            end
            op_sh: begin
                lane_strobe = 4'b0011 << {s1_addr[1], 1'b0};
                lane_data   = data_w'(s1_data[15:0]) << {s1_addr[1], 4'b0000};
            end
            default: begin
                lane_strobe = 4'b1111;
                lane_data   = s1_data;
            end
        endcase
    end

    // everything in flight is younger than a flushing branch
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= dispatch.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag    <= dispatch.tag;
        s1_op     <= dispatch.op;
        s1_addr   <= dispatch.a + dispatch.offset;
        s1_data   <= dispatch.b;
        s2_tag    <= s1_tag;
        s2_addr   <= s1_addr;
        s2_data   <= lane_data;
        s2_strobe <= lane_strobe;
        s3_tag    <= s2_tag;
        s3_addr   <= {s2_addr[data_w-1:2], 2'b00};
        s3_data   <= s2_data;
        s3_strobe <= s2_strobe;
    end

    assign complete.valid  = s3_valid;
    assign complete.tag    = s3_tag;
    assign complete.value  = s3_data;
    assign complete.addr   = s3_addr;
    assign complete.strobe = s3_strobe;
    assign complete.taken  = 1'b0;

endmodule

//--- rob/reorder_buffer.sv
module reorder_buffer import rob_pkg::*; #(
    parameter int rob_depth = 8,
    parameter int tag_w     = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    output logic              issue_ready,
    input  op_e               issue_op,
    input  logic [reg_w-1:0]  issue_rd,
    input  logic [data_w-1:0] issue_a,
    input  logic [data_w-1:0] issue_b,
    input  logic [data_w-1:0] issue_pc,
    input  logic [data_w-1:0] issue_offset,
    input  logic              issue_pred_taken,
    dispatch_if.src           alu_dispatch,
    dispatch_if.src           store_dispatch,
    complete_if.dst           alu_complete,
    complete_if.dst           store_complete,
    output logic              commit_valid,
    output logic [reg_w-1:0]  commit_rd,
    output logic [data_w-1:0] commit_value,
    output logic              store_valid,
    output logic [data_w-1:0] store_addr,
    output logic [3:0]        store_strobe,
    output logic [data_w-1:0] store_data,
    output logic              flush,
    output logic [data_w-1:0] flush_pc
);
    logic [tag_w-1:0]     head;
    logic [tag_w-1:0]     tail;
    logic [tag_w:0]       count;
    logic [rob_depth-1:0] ent_valid;
    logic [rob_depth-1:0] ent_done;
    kind_e                ent_kind   [rob_depth];
    logic [reg_w-1:0]     ent_rd     [rob_depth];
    logic                 ent_pred   [rob_depth];
    logic                 ent_taken  [rob_depth];
    logic [data_w-1:0]    ent_value  [rob_depth];
    logic [data_w-1:0]    ent_addr   [rob_depth];
    logic [3:0]           ent_strobe [rob_depth];

    // registered dispatch, shared by both units
    logic              disp_valid;
    logic [tag_w-1:0]  disp_tag;
    kind_e             disp_kind;
    op_e               disp_op;
    logic [data_w-1:0] disp_a;
    logic [data_w-1:0] disp_b;
    logic [data_w-1:0] disp_pc;
    logic [data_w-1:0] disp_offset;

    kind_e issue_kind;
    logic  accept;
    logic  head_ready;
    logic  mispredict;
    logic  retire;
    logic  alu_wr;
    logic  store_wr;

    always_comb begin
        case (issue_op)
            op_beq, op_bne:      issue_kind = kind_branch;
            op_sb, op_sh, op_sw: issue_kind = kind_store;
            default:             issue_kind = kind_reg;
        endcase
    end

    assign issue_ready = (count != rob_depth);
    assign head_ready  = ent_valid[head] && ent_done[head];
    assign mispredict  = head_ready && (ent_kind[head] == kind_branch)
                         && (ent_taken[head] != ent_pred[head]);
    assign retire      = head_ready && !mispredict;
    // an issue racing the flush edge is younger than the branch
    assign accept      = issue_valid && issue_ready && !mispredict;

    // stale completions land on freed entries and are dropped
    assign alu_wr   = alu_complete.valid && ent_valid[alu_complete.tag];
    assign store_wr = store_complete.valid && ent_valid[store_complete.tag];

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_valid    <= '0;
            ent_done     <= '0;
            disp_valid   <= 1'b0;
            commit_valid <= 1'b0;
            store_valid  <= 1'b0;
            flush        <= mispredict && !rst;
        end else begin
            disp_valid   <= accept;
            commit_valid <= retire && (ent_kind[head] == kind_reg);
            store_valid  <= retire && (ent_kind[head] == kind_store);
            flush        <= 1'b0;
            if (accept) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (alu_wr) begin
                ent_done[alu_complete.tag] <= 1'b1;
            end
            if (store_wr) begin
                ent_done[store_complete.tag] <= 1'b1;
            end
            // correct branches just free the entry
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            count <= count + (tag_w+1)'(accept) - (tag_w+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_kind[tail] <= issue_kind;
            ent_rd[tail]   <= issue_rd;
            ent_pred[tail] <= issue_pred_taken;
            disp_tag       <= tail;
            disp_kind      <= issue_kind;
            disp_op        <= issue_op;
            disp_a         <= issue_a;
            disp_b         <= issue_b;
            disp_pc        <= issue_pc;
            disp_offset    <= issue_offset;
        end
        if (alu_wr) begin
            ent_value[alu_complete.tag]  <= alu_complete.value;
            ent_addr[alu_complete.tag]   <= alu_complete.addr;
            ent_strobe[alu_complete.tag] <= alu_complete.strobe;
            ent_taken[alu_complete.tag]  <= alu_complete.taken;
        end
        if (store_wr) begin
            ent_value[store_complete.tag]  <= store_complete.value;
            ent_addr[store_complete.tag]   <= store_complete.addr;
            ent_strobe[store_complete.tag] <= store_complete.strobe;
            ent_taken[store_complete.tag]  <= store_complete.taken;
        end
        if (head_ready) begin
            commit_rd    <= ent_rd[head];
            commit_value <= ent_value[head];
            store_addr   <= ent_addr[head];
            store_strobe <= ent_strobe[head];
            store_data   <= ent_value[head];
            flush_pc     <= ent_addr[head];
        end
    end

    // steer by kind
    assign alu_dispatch.valid    = disp_valid && (disp_kind != kind_store);
    assign alu_dispatch.tag      = disp_tag;
    assign alu_dispatch.op       = disp_op;
    assign alu_dispatch.a        = disp_a;
    assign alu_dispatch.b        = disp_b;
    assign alu_dispatch.pc       = disp_pc;
    assign alu_dispatch.offset   = disp_offset;

    assign store_dispatch.valid  = disp_valid && (disp_kind == kind_store);
    assign store_dispatch.tag    = disp_tag;
    assign store_dispatch.op     = disp_op;
    assign store_dispatch.a      = disp_a;
    assign store_dispatch.b      = disp_b;
    assign store_dispatch.pc     = disp_pc;
    assign store_dispatch.offset = disp_offset;

endmodule

//--- src.f
common/rob_pkg.sv
common/dispatch_if.sv
common/complete_if.sv
rob/reorder_buffer.sv
logic/alu_unit.sv
logic/store_align_unit.sv
logic/ooo_backend_top.sv
verification/ooo_backend_assertions.sv
verification/tb_ooo_backend.sv

//--- verification/ooo_backend_assertions.sv
module ooo_backend_assertions (
    input logic clk,
    input logic rst,
    input logic commit_valid,
    input logic store_valid,
    input logic flush
);
    int failures = 0;

    // one retirement kind per cycle
    one_retire_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({commit_valid, store_valid, flush}))
        else begin
            $error("more than one retire strobe high in the same cycle");
            failures++;
        end

    flush_single_cycle: assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush)
        else begin
            $error("flush held for two cycles");
            failures++;
        end

    // retire registers clear on the reset edge
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !(commit_valid || store_valid || flush))
        else begin
            $error("retire strobe high during reset");
            failures++;
        end

endmodule

bind ooo_backend_top ooo_backend_assertions ooo_backend_assertions_i (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit_valid),
    .store_valid  (store_valid),
    .flush        (flush)
);

//--- verification/tb_ooo_backend.sv
module tb_ooo_backend import rob_pkg::*; ();

    typedef enum {exp_commit, exp_store, exp_silent, exp_flush} exp_kind_e;

    typedef struct {
        op_e               op;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] pc;
        logic [data_w-1:0] offset;
        logic              pred;
    } instr_t;

    typedef struct {
        exp_kind_e         kind;
        logic [reg_w-1:0]  rd;
        logic [data_w-1:0] value;
        logic [data_w-1:0] addr;
        logic [3:0]        strobe;
    } expect_t;

    // 20 + 12 + 9 + 8 + 8 + 300 instructions over all tests
    localparam int total_instrs = 357;
    localparam int drain_limit  = 200;

    logic              clk;
    logic              rst;
    logic              issue_valid;
    logic              issue_ready;
    op_e               issue_op;
    logic [reg_w-1:0]  issue_rd;
    logic [data_w-1:0] issue_a;
    logic [data_w-1:0] issue_b;
    logic [data_w-1:0] issue_pc;
    logic [data_w-1:0] issue_offset;
    logic              issue_pred_taken;
    logic              commit_valid;
    logic [reg_w-1:0]  commit_rd;
    logic [data_w-1:0] commit_value;
    logic              store_valid;
    logic [data_w-1:0] store_addr;
    logic [3:0]        store_strobe;
    logic [data_w-1:0] store_data;
    logic              flush;
    logic [data_w-1:0] flush_pc;

    expect_t           exp_q[$];
    logic              in_shadow;
    logic [data_w-1:0] pc_counter;
    int                errors;
    int                checks;
    int                test_no;
    int                err_mark;
    int                chk_mark;
    int                i;
    int                j;
    logic [data_w-1:0] v;

    ooo_backend_top #(
        .rob_depth (8)
    ) ooo_backend_top_i (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .issue_ready      (issue_ready),
        .issue_op         (issue_op),
        .issue_rd         (issue_rd),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .issue_pc         (issue_pc),
        .issue_offset     (issue_offset),
        .issue_pred_taken (issue_pred_taken),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_value     (commit_value),
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_strobe     (store_strobe),
        .store_data       (store_data),
        .flush            (flush),
        .flush_pc         (flush_pc)
    );

    always #2 clk = ~clk;

    // expected retirement of one instruction
    function automatic expect_t predict_retirement(input instr_t ins);
        expect_t           e;
        logic [data_w-1:0] ea;
        logic              taken;
        e.kind   = exp_commit;
        e.rd     = ins.rd;
        e.value  = '0;
        e.addr   = '0;
        e.strobe = 4'b0000;
        ea       = ins.a + ins.offset;
        case (ins.op)
            op_add: e.value = ins.a + ins.b;
            op_sub: e.value = ins.a - ins.b;
            op_xor: e.value = ins.a ^ ins.b;
            op_beq, op_bne: begin
                taken  = (ins.op == op_beq) ? (ins.a == ins.b) : (ins.a != ins.b);
                e.addr = taken ? ins.pc + ins.offset : ins.pc + 32'd4;
                e.kind = (taken == ins.pred) ? exp_silent : exp_flush;
            end
            default: begin
                e.kind = exp_store;
                e.addr = ea & 32'hffff_fffc;
                if (ins.op == op_sb) begin
                    e.strobe[ea[1:0]]         = 1'b1;
                    e.value[8*ea[1:0] +: 8] = ins.b[7:0];
                end else if (ins.op == op_sh) begin
                    e.strobe = ea[1] ? 4'b1100 : 4'b0011;
                    e.value  = ea[1] ? {ins.b[15:0], 16'h0} : {16'h0, ins.b[15:0]};
                end else begin
                    e.strobe = 4'b1111;
                    e.value  = ins.b;
                end
            end
        endcase
        return e;
    endfunction

    function automatic instr_t make_instr(input op_e op, input logic [data_w-1:0] a,
                                          input logic [data_w-1:0] b,
                                          input logic [data_w-1:0] offset, input logic pred);
        instr_t ins;
        ins.op     = op;
        ins.rd     = reg_w'($urandom_range(0, 31));
        ins.a      = a;
        ins.b      = b;
        ins.pc     = '0;
        ins.offset = offset;
        ins.pred   = pred;
        return ins;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        foreach (exp_q[k]) begin
            if (exp_q[k].kind != exp_silent) begin
                n++;
            end
        end
        return n;
    endfunction

    // ready and flush are registered, so the falling edge sees the next rising edge
    task automatic issue_instr(input instr_t ins);
        expect_t e;
        logic    ready_seen;
        logic    flush_seen;
        ins.pc     = pc_counter;
        pc_counter = pc_counter + 32'd4;
        e          = predict_retirement(ins);
        ready_seen = 1'b0;
        flush_seen = 1'b0;
        while (!ready_seen) begin
            @(negedge clk);
            issue_valid      = 1'b1;
            issue_op         = ins.op;
            issue_rd         = ins.rd;
            issue_a          = ins.a;
            issue_b          = ins.b;
            issue_pc         = ins.pc;
            issue_offset     = ins.offset;
            issue_pred_taken = ins.pred;
            ready_seen       = issue_ready;
            flush_seen       = flush;
            @(posedge clk);
        end
        // accepted on the flush edge means younger than nothing pending
        if (in_shadow && flush_seen) begin
            in_shadow = 1'b0;
        end
        if (!in_shadow) begin
            exp_q.push_back(e);
            if (e.kind == exp_flush) begin
                in_shadow = 1'b1;
            end
        end
    endtask

    task automatic check_retirement();
        expect_t e;
        while (exp_q.size() > 0 && exp_q[0].kind == exp_silent) begin
            exp_q.delete(0);
        end
        checks++;
        if (exp_q.size() == 0) begin
            $display("** Error at %0t: retirement seen while none was expected", $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            if (e.kind == exp_commit) begin
                if (!commit_valid || commit_rd !== e.rd || commit_value !== e.value) begin
                    $display("** Error at %0t: commit rd %0d value %h, expected rd %0d value %h",
                             $time, commit_rd, commit_value, e.rd, e.value);
                    errors++;
                end
            end else if (e.kind == exp_store) begin
                if (!store_valid || store_addr !== e.addr || store_strobe !== e.strobe
                    || store_data !== e.value) begin
                    $display("** Error at %0t: store %h/%b/%h, expected %h/%b/%h", $time,
                             store_addr, store_strobe, store_data, e.addr, e.strobe, e.value);
                    errors++;
                end
            end else begin
                if (!flush || flush_pc !== e.addr) begin
                    $display("** Error at %0t: flush %b pc %h, expected flush to pc %h",
                             $time, flush, flush_pc, e.addr);
                    errors++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && (commit_valid || store_valid || flush)) begin
            check_retirement();
        end
    end

    task automatic drain_queue();
        int waited;
        waited = 0;
        @(negedge clk);
        issue_valid = 1'b0;
        while (pending_count() > 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (pending_count() > 0) begin
            $display("retirement missing: %0d expected retirements never arrived",
                     pending_count());
            errors++;
        end
        if (issue_ready !== 1'b1) begin
            $display("** Error at %0t: issue_ready %b after the retirements drained, expected 1",
                     $time, issue_ready);
            errors++;
        end
        exp_q.delete();
        in_shadow = 1'b0;
    endtask

    task automatic start_test();
        test_no++;
        err_mark = errors;
        chk_mark = checks;
    endtask

    task automatic finish_test(input string name);
        drain_queue();
        $display("test %0d %s: %0d retirements checked, %0d errors", test_no, name,
                 checks - chk_mark, errors - err_mark);
    endtask

    initial begin
        repeat (total_instrs * 40 + 200) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h0e97786b));
        clk              = 1'b0;
        rst              = 1'b1;
        issue_valid      = 1'b0;
        issue_op         = op_add;
        issue_rd         = '0;
        issue_a          = '0;
        issue_b          = '0;
        issue_pc         = '0;
        issue_offset     = '0;
        issue_pred_taken = 1'b0;
        in_shadow        = 1'b0;
        pc_counter       = 32'h0000_1000;
        errors           = 0;
        checks           = 0;
        test_no          = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (issue_ready !== 1'b1) begin
            $display("** Error at %0t: issue_ready %b after reset, expected 1",
                     $time, issue_ready);
            errors++;
        end

        start_test();
        for (i = 0; i < 20; i++) begin
            issue_instr(make_instr(op_e'(3'($urandom_range(0, 2))), $urandom(), $urandom(),
                                   '0, 1'b0));
        end
        finish_test("alu sequence");

        // sb, sh, sw at each low address alignment
        start_test();
        for (i = 0; i < 3; i++) begin
            for (j = 0; j < 4; j++) begin
                issue_instr(make_instr(op_e'(3'(5 + i)), $urandom() & 32'hffff_fffc, $urandom(),
                                       ($urandom_range(0, 63) << 2) | j, 1'b0));
            end
        end
        finish_test("store alignment");

        start_test();
        for (i = 0; i < 3; i++) begin
            issue_instr(make_instr(op_sw, $urandom(), $urandom(), 32'd8, 1'b0));
            issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
            issue_instr(make_instr(op_sub, $urandom(), $urandom(), '0, 1'b0));
        end
        finish_test("store before alu");

        start_test();
        v = $urandom();
        issue_instr(make_instr(op_beq, v, v, 32'd64, 1'b1));
        issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        issue_instr(make_instr(op_beq, v, v + 32'd1, 32'd64, 1'b0));
        issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        issue_instr(make_instr(op_bne, v, v ^ 32'd1, 32'd64, 1'b1));
        issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        issue_instr(make_instr(op_bne, v, v, 32'd64, 1'b0));
        issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        finish_test("predicted branches");

        // taken beq predicted not taken, three younger ones in its shadow
        start_test();
        v = $urandom();
        issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        issue_instr(make_instr(op_beq, v, v, 32'hffff_ffe0, 1'b0));
        issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        issue_instr(make_instr(op_sw, $urandom(), $urandom(), 32'd4, 1'b0));
        issue_instr(make_instr(op_xor, $urandom(), $urandom(), '0, 1'b0));
        drain_queue();
        for (i = 0; i < 3; i++) begin
            issue_instr(make_instr(op_add, $urandom(), $urandom(), '0, 1'b0));
        end
        finish_test("mispredicted branch");

        start_test();
        for (i = 0; i < 300; i++) begin
            v = $urandom();
            issue_instr(make_instr(op_e'(3'($urandom_range(0, 7))), v,
                                   $urandom_range(0, 1) ? v : $urandom(),
                                   ($urandom_range(0, 255) << 2) - 32'd512,
                                   1'($urandom_range(0, 1))));
        end
        finish_test("random mix");

        errors = errors + ooo_backend_top_i.ooo_backend_assertions_i.failures;
        $display("tests %0d, retirements checked %0d, errors %0d", test_no, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
